//--- src/bp_pkg.sv
package bp_pkg;

    typedef logic [31:0] pc_t; // instruction address.

    // 2-bit saturating direction counter, the upper bit is the prediction.
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_init = 2'd1; // weakly not taken.
    localparam ctr_t ctr_max  = 2'd3;
    localparam ctr_t ctr_min  = 2'd0;

    typedef enum logic [1:0] {
        strong_local,
        weak_local,
        weak_global,
        strong_global
    } sel_t;

    typedef struct packed {
        pc_t pc;
    } lookup_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken; // resolved direction.
    } update_t;

    typedef struct packed {
        logic taken;   // prediction for the lookup pc.
        logic mispred; // only meaningful with update valid.
    } pred_t;

    // moves a counter one step toward the resolved direction.
    function automatic ctr_t ctr_next(ctr_t ctr, logic taken);
        ctr_t next;
        next = ctr;
        if (taken && ctr != ctr_max) begin
            next = ctr + 2'd1;
        end else if (!taken && ctr != ctr_min) begin
            next = ctr - 2'd1;
        end
        return next;
    endfunction

endpackage : bp_pkg

//--- src/global_predictor.sv
`timescale 1ns/10ps

module global_predictor #(
    parameter int pc_offset = 2,
    parameter int ghr_bits  = 6
) (
    input  logic            clk,
    input  logic            rst,
    input  bp_pkg::lookup_t lookup,
    input  bp_pkg::update_t update,
    output logic            taken,
    output logic            mispred
);

    localparam int rows = 2 ** ghr_bits;

    typedef logic [ghr_bits-1:0] gidx_t;

    gidx_t        ghr;
    gidx_t        lookup_pc_bits;
    gidx_t        update_pc_bits;
    gidx_t        lookup_idx;
    gidx_t        update_idx;
    bp_pkg::ctr_t ctr_table [rows];
    bp_pkg::ctr_t lookup_ctr;
    bp_pkg::ctr_t update_ctr;

    assign lookup_pc_bits = lookup.pc[pc_offset +: ghr_bits];
    assign update_pc_bits = update.pc[pc_offset +: ghr_bits];

    // both ports hash with the history as it stands in this cycle.
    assign lookup_idx = lookup_pc_bits ^ ghr;
    assign update_idx = update_pc_bits ^ ghr;

    assign lookup_ctr = ctr_table[lookup_idx];
    assign update_ctr = ctr_table[update_idx];

    assign taken   = lookup_ctr[1];
    assign mispred = update_ctr[1] != update.taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (update.valid) begin
            ghr <= {ghr[ghr_bits-2:0], update.taken}; // newest outcome in bit 0.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rows; i++) begin
                ctr_table[i] <= bp_pkg::ctr_init;
            end
        end else if (update.valid) begin
            ctr_table[update_idx] <= bp_pkg::ctr_next(update_ctr, update.taken);
        end
    end

endmodule : global_predictor

//--- src/local_predictor.sv
`timescale 1ns/10ps

module local_predictor #(
    parameter int pc_offset  = 2,
    parameter int lrow_bits  = 5,
    parameter int lhist_bits = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  bp_pkg::lookup_t lookup,
    input  bp_pkg::update_t update,
    output logic            taken,
    output logic            mispred
);

    localparam int hist_rows = 2 ** lrow_bits;
    localparam int ctr_rows  = 2 ** lhist_bits;

    typedef logic [lrow_bits-1:0]  lrow_t;
    typedef logic [lhist_bits-1:0] lhist_t;

    lhist_t       hist_table [hist_rows];
    bp_pkg::ctr_t ctr_table [ctr_rows];

    lrow_t        lookup_row;
    lrow_t        update_row;
    lhist_t       lookup_hist;
    lhist_t       update_hist;
    lhist_t       update_hist_next;
    bp_pkg::ctr_t lookup_ctr;
    bp_pkg::ctr_t update_ctr;
    bp_pkg::ctr_t update_ctr_next;

    assign lookup_row = lookup.pc[pc_offset +: lrow_bits];
    assign update_row = update.pc[pc_offset +: lrow_bits];

    // first level, the branch's own recent outcomes.
    assign lookup_hist = hist_table[lookup_row];
    assign update_hist = hist_table[update_row];

    // second level, one counter per history pattern.
    assign lookup_ctr = ctr_table[lookup_hist];
    assign update_ctr = ctr_table[update_hist];

    assign taken   = lookup_ctr[1];
    assign mispred = update_ctr[1] != update.taken;

    // the counter trains at the pattern seen before this outcome.
    assign update_ctr_next  = bp_pkg::ctr_next(update_ctr, update.taken);
    assign update_hist_next = {update_hist[lhist_bits-2:0], update.taken};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < hist_rows; i++) begin
                hist_table[i] <= '0;
            end
        end else if (update.valid) begin
            hist_table[update_row] <= update_hist_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ctr_rows; i++) begin
                ctr_table[i] <= bp_pkg::ctr_init;
            end
        end else if (update.valid) begin
            ctr_table[update_hist] <= update_ctr_next;
        end
    end

endmodule : local_predictor

//--- src/tournament_chooser.sv
`timescale 1ns/10ps

module tournament_chooser #(
    parameter int pc_offset = 2,
    parameter int sel_bits  = 5
) (
    input  logic            clk,
    input  logic            rst,
    input  bp_pkg::lookup_t lookup,
    input  bp_pkg::update_t update,
    input  logic            g_taken,
    input  logic            l_taken,
    input  logic            g_mispred,
    input  logic            l_mispred,
    output bp_pkg::pred_t   pred
);

    localparam int rows = 2 ** sel_bits;

    typedef logic [sel_bits-1:0] srow_t;

    bp_pkg::sel_t sel_table [rows];
    bp_pkg::sel_t lookup_sel;
    bp_pkg::sel_t update_sel;
    bp_pkg::sel_t update_sel_next;
    srow_t        lookup_row;
    srow_t        update_row;
    logic         same_row;

    assign lookup_row = lookup.pc[pc_offset +: sel_bits];
    assign update_row = update.pc[pc_offset +: sel_bits];
    assign same_row   = update.valid && (lookup_row == update_row);

    assign update_sel = sel_table[update_row];
    assign lookup_sel = same_row ? update_sel_next : sel_table[lookup_row]; // forwarded.

    // only a disagreement in correctness says which predictor is better.
    always_comb begin
        update_sel_next = update_sel;
        if (update.valid && (l_mispred ^ g_mispred)) begin
            unique case (update_sel)
                bp_pkg::strong_local: begin
                    if (l_mispred) update_sel_next = bp_pkg::weak_local;
                end
                bp_pkg::weak_local: begin
                    if (l_mispred) update_sel_next = bp_pkg::weak_global;
                    else update_sel_next = bp_pkg::strong_local;
                end
                bp_pkg::weak_global: begin
                    if (g_mispred) update_sel_next = bp_pkg::weak_local;
                    else update_sel_next = bp_pkg::strong_global;
                end
                bp_pkg::strong_global: begin
                    if (g_mispred) update_sel_next = bp_pkg::weak_global;
                end
            endcase
        end
    end

    always_comb begin
        unique case (lookup_sel)
            bp_pkg::strong_local, bp_pkg::weak_local: pred.taken = l_taken;
            bp_pkg::weak_global, bp_pkg::strong_global: pred.taken = g_taken;
        endcase
    end

    // the report uses the state that chose for this branch before training.
    always_comb begin
        unique case (update_sel)
            bp_pkg::strong_local, bp_pkg::weak_local: pred.mispred = l_mispred;
            bp_pkg::weak_global, bp_pkg::strong_global: pred.mispred = g_mispred;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rows; i++) begin
                sel_table[i] <= bp_pkg::weak_local;
            end
        end else if (update.valid) begin
            sel_table[update_row] <= update_sel_next;
        end
    end

endmodule : tournament_chooser

//--- src/branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor #(
    parameter int pc_offset  = 2,
    parameter int ghr_bits   = 6,
    parameter int lrow_bits  = 5,
    parameter int lhist_bits = 4,
    parameter int sel_bits   = 5
) (
    input  logic            clk,
    input  logic            rst,
    input  bp_pkg::lookup_t lookup,
    input  bp_pkg::update_t update,
    output bp_pkg::pred_t   pred
);

    logic g_taken;
    logic g_mispred;
    logic l_taken;
    logic l_mispred;

    global_predictor #(
        .pc_offset (pc_offset),
        .ghr_bits  (ghr_bits)
    ) i_global_predictor (
        .clk     (clk),
        .rst     (rst),
        .lookup  (lookup),
        .update  (update),
        .taken   (g_taken),
        .mispred (g_mispred)
    );

    local_predictor #(
        .pc_offset  (pc_offset),
        .lrow_bits  (lrow_bits),
        .lhist_bits (lhist_bits)
    ) i_local_predictor (
        .clk     (clk),
        .rst     (rst),
        .lookup  (lookup),
        .update  (update),
        .taken   (l_taken),
        .mispred (l_mispred)
    );

    tournament_chooser #(
        .pc_offset (pc_offset),
        .sel_bits  (sel_bits)
    ) i_tournament_chooser (
        .clk       (clk),
        .rst       (rst),
        .lookup    (lookup),
        .update    (update),
        .g_taken   (g_taken),
        .l_taken   (l_taken),
        .g_mispred (g_mispred),
        .l_mispred (l_mispred),
        .pred      (pred)
    );

endmodule : branch_predictor

//--- test/branch_predictor_asserts.sv
`timescale 1ns/10ps

module branch_predictor_asserts #(
    parameter int sel_bits = 5
) (
    input logic            clk,
    input logic            rst,
    input bp_pkg::update_t update,
    input bp_pkg::pred_t   pred,
    input bp_pkg::sel_t    sel_table [2 ** sel_bits]
);

    int fail_count = 0; // failed assertions so far.

    generate
        for (genvar r = 0; r < 2 ** sel_bits; r++) begin : g_row
            hold_without_update: assert property (
                @(posedge clk) disable iff (rst) !update.valid |=> $stable(sel_table[r])
            ) else begin
                $error("selector row %0d changed without a valid update", r);
                fail_count++;
            end

            // a selector moves at most one state per clock.
            single_step: assert property (
                @(posedge clk) disable iff (rst)
                    (int'(sel_table[r]) <= int'($past(sel_table[r])) + 1) &&
                    (int'(sel_table[r]) + 1 >= int'($past(sel_table[r])))
            ) else begin
                $error("selector row %0d skipped a state", r);
                fail_count++;
            end
        end
    endgenerate

    not_taken_after_reset: assert property (@(posedge clk) $fell(rst) |-> !pred.taken)
    else begin
        $error("prediction is taken right after reset");
        fail_count++;
    end

endmodule : branch_predictor_asserts

bind tournament_chooser branch_predictor_asserts #(
    .sel_bits (sel_bits)
) i_chooser_asserts (
    .clk       (clk),
    .rst       (rst),
    .update    (update),
    .pred      (pred),
    .sel_table (sel_table)
);

//--- test/branch_predictor_tb.sv
`timescale 1ns/10ps

module branch_predictor_tb;

    localparam int pc_offset    = 2;
    localparam int ghr_bits     = 6;
    localparam int lrow_bits    = 5;
    localparam int lhist_bits   = 4;
    localparam int sel_bits     = 5;
    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int test_cycles  = reset_cycles + 6 + 12 + 48 + 244 + 24 + 400;

    logic            clk;
    logic            rst;
    bp_pkg::lookup_t lookup;
    bp_pkg::update_t update;
    bp_pkg::pred_t   pred;
    bp_pkg::pred_t   last_pred;
    int              fwd_changes;

    logic [ghr_bits-1:0]   model_ghr;
    bp_pkg::ctr_t          model_gctr [2 ** ghr_bits];
    logic [lhist_bits-1:0] model_lhist [2 ** lrow_bits];
    bp_pkg::ctr_t          model_lctr [2 ** lhist_bits];
    bp_pkg::sel_t          model_sel [2 ** sel_bits];

    branch_predictor #(
        .pc_offset  (pc_offset),
        .ghr_bits   (ghr_bits),
        .lrow_bits  (lrow_bits),
        .lhist_bits (lhist_bits),
        .sel_bits   (sel_bits)
    ) i_branch_predictor (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup),
        .update (update),
        .pred   (pred)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(test_cycles * clk_period * 3 / 2);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    function automatic bp_pkg::ctr_t saturate(bp_pkg::ctr_t ctr, logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

    // one step toward the predictor that was right, ends saturate.
    function automatic bp_pkg::sel_t chooser_step(bp_pkg::sel_t sel, logic l_wrong,
                                                  logic g_wrong);
        if (l_wrong && !g_wrong && sel != bp_pkg::strong_global) begin
            return bp_pkg::sel_t'(sel + 1);
        end
        if (g_wrong && !l_wrong && sel != bp_pkg::strong_local) begin
            return bp_pkg::sel_t'(sel - 1);
        end
        return sel;
    endfunction

    function automatic logic picks_global(bp_pkg::sel_t sel);
        return sel == bp_pkg::weak_global || sel == bp_pkg::strong_global;
    endfunction

    function automatic logic [ghr_bits-1:0] gshare_index(bp_pkg::pc_t pc);
        return pc[pc_offset +: ghr_bits] ^ model_ghr;
    endfunction

    function automatic logic [lrow_bits-1:0] local_row(bp_pkg::pc_t pc);
        return pc[pc_offset +: lrow_bits];
    endfunction

    function automatic logic [sel_bits-1:0] sel_row(bp_pkg::pc_t pc);
        return pc[pc_offset +: sel_bits];
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "test failed");
    endtask

    task automatic check_taken(input bp_pkg::pred_t got, input logic expected,
                               input bp_pkg::pc_t pc);
        if (got.taken !== expected) begin
            $display("FAIL pred.taken pc=%h got=%h expected=%h", pc, got.taken, expected);
            report_failure("lookup prediction mismatch");
        end
    endtask

    task automatic check_mispred(input bp_pkg::pred_t got, input logic expected,
                                 input bp_pkg::pc_t pc);
        if (got.mispred !== expected) begin
            $display("FAIL pred.mispred pc=%h got=%h expected=%h", pc, got.mispred, expected);
            report_failure("mispredict report mismatch");
        end
    endtask

    task automatic model_reset();
        model_ghr = '0;
        foreach (model_gctr[i]) model_gctr[i] = 2'd1;
        foreach (model_lhist[i]) model_lhist[i] = '0;
        foreach (model_lctr[i]) model_lctr[i] = 2'd1;
        foreach (model_sel[i]) model_sel[i] = bp_pkg::weak_local;
    endtask

    // drives one cycle, checks it against the model and then trains the model.
    task automatic run_cycle(input bp_pkg::pc_t lpc, input logic uvalid,
                             input bp_pkg::pc_t upc, input logic utaken);
        logic [ghr_bits-1:0]   g_idx;
        logic [lhist_bits-1:0] l_idx;
        logic [lrow_bits-1:0]  l_row;
        logic [sel_bits-1:0]   s_row;
        logic                  g_wrong;
        logic                  l_wrong;
        logic                  exp_taken;
        logic                  exp_mispred;
        bp_pkg::sel_t          sel_now;
        bp_pkg::sel_t          sel_next;
        bp_pkg::sel_t          lookup_sel;
        lookup.pc = lpc;
        update.valid = uvalid;
        update.pc = upc;
        update.taken = utaken;
        #(clk_period - 20); // 10 ns before the next edge.
        g_idx = gshare_index(upc);
        l_row = local_row(upc);
        l_idx = model_lhist[l_row];
        s_row = sel_row(upc);
        g_wrong = model_gctr[g_idx][1] != utaken;
        l_wrong = model_lctr[l_idx][1] != utaken;
        sel_now = model_sel[s_row];
        sel_next = uvalid ? chooser_step(sel_now, l_wrong, g_wrong) : sel_now;
        if (uvalid && sel_row(lpc) == s_row) begin
            lookup_sel = sel_next; // same row sees the trained selector.
            if (sel_next != sel_now) begin
                fwd_changes++;
            end
        end else begin
            lookup_sel = model_sel[sel_row(lpc)];
        end
        exp_taken = picks_global(lookup_sel) ? model_gctr[gshare_index(lpc)][1]
                                             : model_lctr[model_lhist[local_row(lpc)]][1];
        exp_mispred = picks_global(sel_now) ? g_wrong : l_wrong;
        last_pred = pred;
        check_taken(pred, exp_taken, lpc);
        if (uvalid) begin
            check_mispred(pred, exp_mispred, upc);
        end
        @(posedge clk);
        if (uvalid) begin
            model_gctr[g_idx] = saturate(model_gctr[g_idx], utaken);
            model_ghr = {model_ghr[ghr_bits-2:0], utaken};
            model_lctr[l_idx] = saturate(model_lctr[l_idx], utaken);
            model_lhist[l_row] = {model_lhist[l_row][lhist_bits-2:0], utaken};
            model_sel[s_row] = sel_next;
        end
        #10;
    endtask

    task automatic test_reset_state();
        bp_pkg::pc_t pcs [4] = '{32'h0000_0000, 32'h0000_1000, 32'h0000_2a6c, 32'hffff_fffc};
        foreach (pcs[i]) begin
            run_cycle(pcs[i], 1'b0, 32'h0, 1'b0);
            check_taken(last_pred, 1'b0, pcs[i]);
        end
        run_cycle(32'h0000_1000, 1'b1, 32'h0000_1000, 1'b0);
        check_mispred(last_pred, 1'b0, 32'h0000_1000);
        run_cycle(32'h0000_1010, 1'b1, 32'h0000_1010, 1'b1);
        check_mispred(last_pred, 1'b1, 32'h0000_1010);
    endtask

    task automatic test_always_taken();
        bp_pkg::pc_t pc_e = 32'h0000_0040;
        repeat (10) run_cycle(pc_e, 1'b1, pc_e, 1'b1);
        run_cycle(pc_e, 1'b1, pc_e, 1'b1);
        check_taken(last_pred, 1'b1, pc_e);
        check_mispred(last_pred, 1'b0, pc_e);
        run_cycle(pc_e, 1'b0, pc_e, 1'b0);
        check_taken(last_pred, 1'b1, pc_e);
    endtask

    task automatic test_alternating();
        bp_pkg::pc_t pc_d = 32'h0000_0220;
        logic        outcome = 1'b1;
        for (int i = 0; i < 48; i++) begin
            run_cycle(pc_d, 1'b1, pc_d, outcome);
            if (i >= 40) begin
                check_mispred(last_pred, 1'b0, pc_d);
                check_taken(last_pred, outcome, pc_d);
            end
            outcome = !outcome;
        end
    endtask

    // b repeats the random outcome of a, with filler branches at c in between.
    task automatic test_migration();
        bp_pkg::pc_t pc_a = 32'h0000_0100;
        bp_pkg::pc_t pc_b = 32'h0000_0104;
        bp_pkg::pc_t pc_c = 32'h0000_010c;
        logic        outcome;
        for (int i = 0; i < 40; i++) begin
            outcome = 1'($urandom % 2);
            repeat (4) run_cycle(pc_b, 1'b1, pc_c, 1'b1);
            run_cycle(pc_b, 1'b1, pc_a, outcome);
            run_cycle(pc_b, 1'b1, pc_b, outcome);
        end
        if (!picks_global(model_sel[sel_row(pc_b)])) begin
            report_failure("the chooser did not move to global for the correlated branch");
        end
        repeat (4) run_cycle(pc_b, 1'b0, pc_a, 1'b0);
    endtask

    task automatic test_forwarding();
        bp_pkg::pc_t pc_f = 32'h0000_0058;
        bp_pkg::pc_t pc_g = 32'h0000_00d8; // same chooser row as pc_f.
        int          start_changes = fwd_changes;
        for (int i = 0; i < 24; i++) begin
            run_cycle((i % 2 == 1) ? pc_g : pc_f, 1'b1, pc_f, 1'($urandom % 2));
        end
        if (fwd_changes == start_changes) begin
            report_failure("no update changed the selector of the row being looked up");
        end
    endtask

    task automatic test_random_stream();
        bp_pkg::pc_t pcs [4] = '{32'h0000_0300, 32'h0000_0310, 32'h0000_0324, 32'h0000_03a8};
        int          bias [4] = '{90, 70, 30, 10};
        int          k;
        bp_pkg::pc_t lpc;
        logic        uvalid;
        logic        utaken;
        for (int i = 0; i < 400; i++) begin
            k = int'($urandom % 4);
            lpc = $urandom & 32'h0000_03fc;
            uvalid = ($urandom % 4) != 0;
            utaken = ($urandom % 100) < bias[k]; // percent taken per branch.
            run_cycle(lpc, uvalid, pcs[k], utaken);
        end
    endtask

    initial begin
        int seed;
        seed = 66465;
        void'($urandom(seed));
        rst = 1'b1;
        lookup = '0;
        update = '0;
        fwd_changes = 0;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset_state();
        test_always_taken();
        test_alternating();
        test_migration();
        test_forwarding();
        test_random_stream();
        if (i_branch_predictor.i_tournament_chooser.i_chooser_asserts.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("concurrent assertions failed during the run");
            $display("*** FAILED ***");
            $fatal(1, "assertion failures");
        end
    end

endmodule : branch_predictor_tb

//--- branch_predictor.f
src/bp_pkg.sv
src/global_predictor.sv
src/local_predictor.sv
src/tournament_chooser.sv
src/branch_predictor.sv
test/branch_predictor_asserts.sv
test/branch_predictor_tb.sv
